/* deca_macros.svh */
`ifndef DECA_MACROS_SVH
`define DECA_MACROS_SVH

// bus and port widths
`define DECA_DATA_W 32
`define DECA_GPIO_W 8
`define DECA_SW_N 3

// address fields: slave select and register select
`define DECA_SEL_LSB 8
`define DECA_SEL_MSB 11
`define DECA_REG_LSB 2
`define DECA_REG_MSB 4

// slave indices, anything above timer is unmapped
`define DECA_SLV_GPIO_A 4'd0
`define DECA_SLV_GPIO_B 4'd1
`define DECA_SLV_SWITCH 4'd2
`define DECA_SLV_TIMER 4'd3

// gpio register offsets
`define DECA_GPIO_OUT 3'd0
`define DECA_GPIO_DIR 3'd1
`define DECA_GPIO_IN 3'd2

// switch block offsets
`define DECA_SW_RAW 3'd0
`define DECA_SW_PEND 3'd1
`define DECA_SW_EN 3'd2

// machine timer offsets
`define DECA_TMR_CNT_LO 3'd0
`define DECA_TMR_CNT_HI 3'd1
`define DECA_TMR_CMP_LO 3'd2
`define DECA_TMR_CMP_HI 3'd3

`endif

/* deca_pkg.sv */
`include "deca_macros.svh"

package deca_pkg;

  // slave index taken from the select field of the address
  typedef logic [`DECA_SEL_MSB-`DECA_SEL_LSB:0] slv_sel_t;

  // two bus words of the 64-bit timer values
  typedef struct packed {
    logic [`DECA_DATA_W-1:0] hi;
    logic [`DECA_DATA_W-1:0] lo;
  } mtime_words_t;

  // same 64 bits, seen as one count or as hi/lo words
  typedef union packed {
    logic [2*`DECA_DATA_W-1:0] count;
    mtime_words_t w;
  } mtime_u;

endpackage

/* wb_addr_decode.sv */
`include "deca_macros.svh"

module wb_addr_decode import deca_pkg::*; (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  input  logic wb_we_i,
  input  logic [`DECA_DATA_W-1:0] wb_adr_i,
  input  logic wb_ack_i,
  output logic gpio_a_wr_o,
  output logic gpio_b_wr_o,
  output logic switch_wr_o,
  output logic timer_wr_o,
  output logic req_o,
  output logic [`DECA_REG_MSB-`DECA_REG_LSB:0] reg_idx_o,
  output slv_sel_t sel_o,
  output logic unmapped_o
);

  logic served_q;
  logic new_req;
  logic wr_req;
  slv_sel_t sel;

  // request already answered, held until the master drops stb
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      served_q <= 1'b0;
    end else begin
      served_q <= wb_cyc_i & wb_stb_i & (served_q | wb_ack_i);
    end
  end

  // new only while not in or after its ack cycle
  assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_i & ~served_q;
  assign wr_req  = new_req & wb_we_i;

  // address fields
  assign sel       = wb_adr_i[`DECA_SEL_MSB:`DECA_SEL_LSB];
  assign reg_idx_o = wb_adr_i[`DECA_REG_MSB:`DECA_REG_LSB];

  // write strobes, same cycle as the request
  assign gpio_a_wr_o = wr_req & (sel == `DECA_SLV_GPIO_A);
  assign gpio_b_wr_o = wr_req & (sel == `DECA_SLV_GPIO_B);
  assign switch_wr_o = wr_req & (sel == `DECA_SLV_SWITCH);
  assign timer_wr_o  = wr_req & (sel == `DECA_SLV_TIMER);

  // to the result stage
  assign req_o      = new_req;
  assign sel_o      = sel;
  assign unmapped_o = sel > `DECA_SLV_TIMER;

endmodule

/* gpio_port.sv */
`include "deca_macros.svh"

module gpio_port (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic wr_i,
  input  logic [`DECA_REG_MSB-`DECA_REG_LSB:0] reg_idx_i,
  input  logic [`DECA_DATA_W-1:0] wdata_i,
  input  logic [`DECA_GPIO_W-1:0] pin_i,
  output logic [`DECA_DATA_W-1:0] rdata_o,
  output logic [`DECA_GPIO_W-1:0] pin_o,
  output logic [`DECA_GPIO_W-1:0] pin_oe_o
);

  logic [`DECA_GPIO_W-1:0] out_q;
  logic [`DECA_GPIO_W-1:0] dir_q;
  logic [`DECA_GPIO_W-1:0] in_meta_q;
  logic [`DECA_GPIO_W-1:0] in_sync_q;

  // output and direction registers
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_i) begin
      case (reg_idx_i)
        `DECA_GPIO_OUT: out_q <= wdata_i[`DECA_GPIO_W-1:0];
        `DECA_GPIO_DIR: dir_q <= wdata_i[`DECA_GPIO_W-1:0];
        // input reg is read-only
        default: ;
      endcase
    end
  end

  // two-flop input sync
  always_ff @(posedge i_clk) begin
    in_meta_q <= pin_i;
    in_sync_q <= in_meta_q;
  end

  // read back, zero-extended
  always_comb begin
    rdata_o = '0;
    case (reg_idx_i)
      `DECA_GPIO_OUT: rdata_o[`DECA_GPIO_W-1:0] = out_q;
      `DECA_GPIO_DIR: rdata_o[`DECA_GPIO_W-1:0] = dir_q;
      `DECA_GPIO_IN:  rdata_o[`DECA_GPIO_W-1:0] = in_sync_q;
      default: ;
    endcase
  end

  assign pin_o    = out_q;
  assign pin_oe_o = dir_q;

endmodule

/* switch_irq_ctrl.sv */
`include "deca_macros.svh"

module switch_irq_ctrl (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic wr_i,
  input  logic [`DECA_REG_MSB-`DECA_REG_LSB:0] reg_idx_i,
  input  logic [`DECA_DATA_W-1:0] wdata_i,
  input  logic [`DECA_SW_N-1:0] switch_i,
  output logic [`DECA_DATA_W-1:0] rdata_o,
  output logic irq_o
);

  logic [`DECA_SW_N-1:0] sw_meta_q;
  logic [`DECA_SW_N-1:0] sw_sync_q;
  logic [`DECA_SW_N-1:0] sw_prev_q;
  logic [`DECA_SW_N-1:0] rise_q;
  logic [`DECA_SW_N-1:0] pend_q;
  logic [`DECA_SW_N-1:0] en_q;
  logic [`DECA_SW_N-1:0] clr;
  logic irq_q;

  // sync chain, then registered rising-edge detect
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
      sw_prev_q <= '0;
      rise_q    <= '0;
    end else begin
      sw_meta_q <= switch_i;
      sw_sync_q <= sw_meta_q;
      sw_prev_q <= sw_sync_q;
      rise_q    <= sw_sync_q & ~sw_prev_q;
    end
  end

  // write 1 to clear pending
  assign clr = (wr_i && reg_idx_i == `DECA_SW_PEND) ? wdata_i[`DECA_SW_N-1:0] : '0;

  // pending and enable; a new edge beats the clear
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      pend_q <= '0;
      en_q   <= '0;
      irq_q  <= 1'b0;
    end else begin
      pend_q <= (pend_q & ~clr) | rise_q;
      if (wr_i && reg_idx_i == `DECA_SW_EN) begin
        en_q <= wdata_i[`DECA_SW_N-1:0];
      end
      irq_q <= |(pend_q & en_q);
    end
  end

  // raw level, pending, enable
  always_comb begin
    rdata_o = '0;
    case (reg_idx_i)
      `DECA_SW_RAW:  rdata_o[`DECA_SW_N-1:0] = sw_sync_q;
      `DECA_SW_PEND: rdata_o[`DECA_SW_N-1:0] = pend_q;
      `DECA_SW_EN:   rdata_o[`DECA_SW_N-1:0] = en_q;
      default: ;
    endcase
  end

  assign irq_o = irq_q;

endmodule

/* machine_timer.sv */
`include "deca_macros.svh"

module machine_timer import deca_pkg::*; (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic wr_i,
  input  logic [`DECA_REG_MSB-`DECA_REG_LSB:0] reg_idx_i,
  input  logic [`DECA_DATA_W-1:0] wdata_i,
  output logic [`DECA_DATA_W-1:0] rdata_o,
  output logic irq_o
);

  mtime_u mtime_q;
  mtime_u mtime_d;
  mtime_u mtimecmp_q;
  logic irq_q;

  // free-running count; a write reloads one half
  always_comb begin
    mtime_d.count = mtime_q.count + 1'b1;
    if (wr_i && reg_idx_i == `DECA_TMR_CNT_LO) begin
      mtime_d.w.lo = wdata_i;
    end
    if (wr_i && reg_idx_i == `DECA_TMR_CNT_HI) begin
      mtime_d.w.hi = wdata_i;
    end
  end

  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      mtime_q.count    <= '0;
      mtimecmp_q.count <= '1;
      irq_q            <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      // compare written by word halves
      if (wr_i && reg_idx_i == `DECA_TMR_CMP_LO) begin
        mtimecmp_q.w.lo <= wdata_i;
      end
      if (wr_i && reg_idx_i == `DECA_TMR_CMP_HI) begin
        mtimecmp_q.w.hi <= wdata_i;
      end
      // level irq while count has reached compare
      irq_q <= mtime_q.count >= mtimecmp_q.count;
    end
  end

  always_comb begin
    case (reg_idx_i)
      `DECA_TMR_CNT_LO: rdata_o = mtime_q.w.lo;
      `DECA_TMR_CNT_HI: rdata_o = mtime_q.w.hi;
      `DECA_TMR_CMP_LO: rdata_o = mtimecmp_q.w.lo;
      `DECA_TMR_CMP_HI: rdata_o = mtimecmp_q.w.hi;
      default:          rdata_o = '0;
    endcase
  end

  assign irq_o = irq_q;

endmodule

/* wb_read_mux.sv */
`include "deca_macros.svh"

module wb_read_mux import deca_pkg::*; (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic req_i,
  input  logic we_i,
  input  slv_sel_t sel_i,
  input  logic unmapped_i,
  input  logic [`DECA_DATA_W-1:0] gpio_a_rdata_i,
  input  logic [`DECA_DATA_W-1:0] gpio_b_rdata_i,
  input  logic [`DECA_DATA_W-1:0] switch_rdata_i,
  input  logic [`DECA_DATA_W-1:0] timer_rdata_i,
  output logic [`DECA_DATA_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  output logic wb_err_o
);

  logic [`DECA_DATA_W-1:0] rdata_sel;
  logic ack_q;
  logic err_q;
  logic [`DECA_DATA_W-1:0] dat_q;

  // pick the addressed slave
  always_comb begin
    case (sel_i)
      `DECA_SLV_GPIO_A: rdata_sel = gpio_a_rdata_i;
      `DECA_SLV_GPIO_B: rdata_sel = gpio_b_rdata_i;
      `DECA_SLV_SWITCH: rdata_sel = switch_rdata_i;
      `DECA_SLV_TIMER:  rdata_sel = timer_rdata_i;
      default:          rdata_sel = '0;
    endcase
  end

  // one-cycle ack pulse, err only for unmapped
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_i;
      err_q <= req_i & unmapped_i;
    end
  end

  // zero on writes, errors and idle cycles
  always_ff @(posedge i_clk) begin
    dat_q <= (req_i && !we_i && !unmapped_i) ? rdata_sel : '0;
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = dat_q;

endmodule

/* deca_periph_top.sv */
`include "deca_macros.svh"

module deca_periph_top import deca_pkg::*; (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic wb_cyc_i,
  input  logic wb_stb_i,
  input  logic wb_we_i,
  input  logic [`DECA_DATA_W-1:0] wb_adr_i,
  input  logic [`DECA_DATA_W-1:0] wb_dat_i,
  input  logic [`DECA_GPIO_W-1:0] gpio_a_i,
  input  logic [`DECA_GPIO_W-1:0] gpio_b_i,
  input  logic [`DECA_SW_N-1:0] switch_i,
  output logic [`DECA_DATA_W-1:0] wb_dat_o,
  output logic wb_ack_o,
  output logic wb_err_o,
  output logic [`DECA_GPIO_W-1:0] gpio_a_o,
  output logic [`DECA_GPIO_W-1:0] gpio_a_oe_o,
  output logic [`DECA_GPIO_W-1:0] gpio_b_o,
  output logic [`DECA_GPIO_W-1:0] gpio_b_oe_o,
  output logic timer_irq_o,
  output logic ext_irq_o
);

  // decoder outputs
  logic gpio_a_wr;
  logic gpio_b_wr;
  logic switch_wr;
  logic timer_wr;
  logic req;
  logic [`DECA_REG_MSB-`DECA_REG_LSB:0] reg_idx;
  slv_sel_t sel;
  logic unmapped;

  // per-slave read data
  logic [`DECA_DATA_W-1:0] gpio_a_rdata;
  logic [`DECA_DATA_W-1:0] gpio_b_rdata;
  logic [`DECA_DATA_W-1:0] switch_rdata;
  logic [`DECA_DATA_W-1:0] timer_rdata;

  wb_addr_decode u_decode (
    .i_clk       (i_clk),
    .clk_reset   (clk_reset),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_ack_i    (wb_ack_o),
    .gpio_a_wr_o (gpio_a_wr),
    .gpio_b_wr_o (gpio_b_wr),
    .switch_wr_o (switch_wr),
    .timer_wr_o  (timer_wr),
    .req_o       (req),
    .reg_idx_o   (reg_idx),
    .sel_o       (sel),
    .unmapped_o  (unmapped)
  );

  gpio_port gpio_a (
    .i_clk     (i_clk),
    .clk_reset (clk_reset),
    .wr_i      (gpio_a_wr),
    .reg_idx_i (reg_idx),
    .wdata_i   (wb_dat_i),
    .pin_i     (gpio_a_i),
    .rdata_o   (gpio_a_rdata),
    .pin_o     (gpio_a_o),
    .pin_oe_o  (gpio_a_oe_o)
  );

  gpio_port gpio_b (
    .i_clk     (i_clk),
    .clk_reset (clk_reset),
    .wr_i      (gpio_b_wr),
    .reg_idx_i (reg_idx),
    .wdata_i   (wb_dat_i),
    .pin_i     (gpio_b_i),
    .rdata_o   (gpio_b_rdata),
    .pin_o     (gpio_b_o),
    .pin_oe_o  (gpio_b_oe_o)
  );

  // key and both slide switches share one external irq
  switch_irq_ctrl u_switch (
    .i_clk     (i_clk),
    .clk_reset (clk_reset),
    .wr_i      (switch_wr),
    .reg_idx_i (reg_idx),
    .wdata_i   (wb_dat_i),
    .switch_i  (switch_i),
    .rdata_o   (switch_rdata),
    .irq_o     (ext_irq_o)
  );

  machine_timer u_timer (
    .i_clk     (i_clk),
    .clk_reset (clk_reset),
    .wr_i      (timer_wr),
    .reg_idx_i (reg_idx),
    .wdata_i   (wb_dat_i),
    .rdata_o   (timer_rdata),
    .irq_o     (timer_irq_o)
  );

  wb_read_mux u_read_mux (
    .i_clk          (i_clk),
    .clk_reset      (clk_reset),
    .req_i          (req),
    .we_i           (wb_we_i),
    .sel_i          (sel),
    .unmapped_i     (unmapped),
    .gpio_a_rdata_i (gpio_a_rdata),
    .gpio_b_rdata_i (gpio_b_rdata),
    .switch_rdata_i (switch_rdata),
    .timer_rdata_i  (timer_rdata),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o)
  );

endmodule

/* tb_checker.sv */
module tb_checker (
  input  logic i_clk,
  input  logic clk_reset,
  input  logic [31:0] wb_dat_o,
  input  logic wb_ack_o,
  input  logic wb_err_o,
  input  logic [7:0] gpio_a_o,
  input  logic [7:0] gpio_a_oe_o,
  input  logic [7:0] gpio_b_o,
  input  logic [7:0] gpio_b_oe_o,
  input  logic timer_irq_o,
  input  logic ext_irq_o,
  input  logic bus_armed,
  input  logic exp_err,
  input  logic exp_gt,
  input  logic [31:0] exp_dat,
  input  logic [31:0] exp_mask,
  input  logic [1:0] chk_kind,
  input  int test_no,
  output int pass_cnt,
  output int fail_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] pins;
  logic [31:0] irqs;
  bit [31:0] last_dat;
  logic ok;
  logic tested;

  // packed views for one compare each
  assign pins = {gpio_b_oe_o, gpio_b_o, gpio_a_oe_o, gpio_a_o};
  assign irqs = {30'd0, ext_irq_o, timer_irq_o};

  always @(posedge i_clk) begin
    ok = 1'b1;
    tested = 1'b0;
    if (!clk_reset && wb_ack_o) begin
      tested = 1'b1;
      // an ack with nothing open means a duplicate or stray pulse
      if (!bus_armed) begin
        $display("test %0d: acknowledge came with no request open", test_no);
        ok = 1'b0;
      end else begin
        if (wb_err_o !== exp_err) begin
          $display("Error test %0d: wb_err_o is %h, expected %h", test_no, wb_err_o, exp_err);
          ok = 1'b0;
        end
        if (exp_gt) begin
          if (wb_dat_o <= last_dat) begin
            $display("Error test %0d: wb_dat_o is %h, expected more than %h",
                     test_no, wb_dat_o, last_dat);
            ok = 1'b0;
          end
        end else if ((wb_dat_o & exp_mask) !== (exp_dat & exp_mask)) begin
          $display("Error test %0d: wb_dat_o is %h, expected %h under mask %h",
                   test_no, wb_dat_o, exp_dat, exp_mask);
          ok = 1'b0;
        end
      end
      last_dat <= wb_dat_o;
    end else if (chk_kind == 2'd1) begin
      tested = 1'b1;
      if ((pins & exp_mask) !== (exp_dat & exp_mask)) begin
        $display("Error test %0d: {gpio_b_oe_o,gpio_b_o,gpio_a_oe_o,gpio_a_o} is %h, expected %h",
                 test_no, pins, exp_dat);
        ok = 1'b0;
      end
    end else if (chk_kind == 2'd2) begin
      tested = 1'b1;
      if ((irqs & exp_mask) !== (exp_dat & exp_mask)) begin
        $display("Error test %0d: {ext_irq_o,timer_irq_o} is %h, expected %h",
                 test_no, irqs[1:0], exp_dat[1:0]);
        ok = 1'b0;
      end
    end
    if (tested && ok) begin
      $display("test %0d: passed", test_no);
      pass_cnt <= pass_cnt + 1;
    end else if (tested) begin
      fail_cnt <= fail_cnt + 1;
    end
  end

endmodule

/* tb_top.sv */
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  // vector memory holds five words per operation
  localparam int MAX_OPS   = 64;
  localparam int ACK_LIMIT = 16;

  logic i_clk;
  logic clk_reset;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [7:0] gpio_a_i;
  logic [7:0] gpio_b_i;
  logic [2:0] switch_i;
  logic [31:0] wb_dat_o;
  logic wb_ack_o;
  logic wb_err_o;
  logic [7:0] gpio_a_o;
  logic [7:0] gpio_a_oe_o;
  logic [7:0] gpio_b_o;
  logic [7:0] gpio_b_oe_o;
  logic timer_irq_o;
  logic ext_irq_o;

  // expectations handed to the checker
  logic bus_armed;
  logic exp_err;
  logic exp_gt;
  logic [31:0] exp_dat;
  logic [31:0] exp_mask;
  logic [1:0] chk_kind;
  int test_no;
  int pass_cnt;
  int fail_cnt;
  int other_fail_cnt;
  logic [31:0] vec [0:5*MAX_OPS-1];

  deca_periph_top dut0 (
    .i_clk       (i_clk),
    .clk_reset   (clk_reset),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .gpio_a_i    (gpio_a_i),
    .gpio_b_i    (gpio_b_i),
    .switch_i    (switch_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .gpio_a_o    (gpio_a_o),
    .gpio_a_oe_o (gpio_a_oe_o),
    .gpio_b_o    (gpio_b_o),
    .gpio_b_oe_o (gpio_b_oe_o),
    .timer_irq_o (timer_irq_o),
    .ext_irq_o   (ext_irq_o)
  );

  tb_checker chk0 (
    .i_clk       (i_clk),
    .clk_reset   (clk_reset),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .gpio_a_o    (gpio_a_o),
    .gpio_a_oe_o (gpio_a_oe_o),
    .gpio_b_o    (gpio_b_o),
    .gpio_b_oe_o (gpio_b_oe_o),
    .timer_irq_o (timer_irq_o),
    .ext_irq_o   (ext_irq_o),
    .bus_armed   (bus_armed),
    .exp_err     (exp_err),
    .exp_gt      (exp_gt),
    .exp_dat     (exp_dat),
    .exp_mask    (exp_mask),
    .chk_kind    (chk_kind),
    .test_no     (test_no),
    .pass_cnt    (pass_cnt),
    .fail_cnt    (fail_cnt)
  );

  // 4 ns period
  always #2 i_clk = ~i_clk;

  // drop the request, then one idle cycle so the next one is new
  task automatic release_bus();
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(posedge i_clk);
  endtask

  // single wishbone access, hold leaves stb up past the ack
  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input logic hold);
    int waited;
    logic keep;
    waited = 0;
    keep = hold;
    wb_cyc_i  <= 1'b1;
    wb_stb_i  <= 1'b1;
    wb_we_i   <= we;
    wb_adr_i  <= adr;
    wb_dat_i  <= dat;
    bus_armed <= 1'b1;
    do begin
      @(posedge i_clk);
      waited++;
    end while (!wb_ack_o && waited < ACK_LIMIT);
    if (!wb_ack_o) begin
      $display("test %0d: no acknowledge from the DUT within %0d cycles", test_no, ACK_LIMIT);
      other_fail_cnt++;
      keep = 1'b0;
    end
    bus_armed <= 1'b0;
    if (!keep) begin
      release_bus();
    end
  endtask

  // ask the checker to compare pins or irqs this cycle
  task automatic pulse_check(input logic [1:0] kind);
    chk_kind <= kind;
    @(posedge i_clk);
    chk_kind <= 2'd0;
  endtask

  // bit 0 timer irq, bit 1 external irq
  task automatic wait_irq(input logic [1:0] mask, input logic [1:0] level, input int limit);
    int waited;
    waited = 0;
    while ((({ext_irq_o, timer_irq_o} & mask) != level) && waited < limit) begin
      @(posedge i_clk);
      waited++;
    end
    if (({ext_irq_o, timer_irq_o} & mask) != level) begin
      $display("test %0d: irq did not reach level %h within %0d cycles", test_no, level, limit);
      other_fail_cnt++;
    end else begin
      pulse_check(2'd2);
    end
  endtask

  initial begin
    int idx;
    logic done;
    logic [31:0] op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    logic [31:0] mask;
    i_clk = 1'b0;
    clk_reset = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    gpio_a_i = '0;
    gpio_b_i = '0;
    switch_i = '0;
    bus_armed = 1'b0;
    exp_err = 1'b0;
    exp_gt = 1'b0;
    exp_dat = '0;
    exp_mask = '0;
    chk_kind = 2'd0;
    test_no = 0;
    other_fail_cnt = 0;
    // unfilled entries read as the end marker
    for (idx = 0; idx < 5*MAX_OPS; idx++) begin
      vec[idx] = '0;
    end
    $readmemh("deca_golden_vectors.txt", vec);

    repeat (2) @(posedge i_clk);
    clk_reset <= 1'b0;

    idx = 0;
    done = 1'b0;
    while (!done && idx < MAX_OPS) begin
      op   = vec[5*idx];
      adr  = vec[5*idx+1];
      dat  = vec[5*idx+2];
      exp  = vec[5*idx+3];
      mask = vec[5*idx+4];
      test_no  <= idx + 1;
      exp_dat  <= exp;
      exp_mask <= mask;
      exp_err  <= (op == 32'h3);
      exp_gt   <= (op == 32'ha);
      case (op)
        32'h0: done = 1'b1;
        32'h1: bus_access(1'b1, adr, dat, 1'b0);
        32'h2, 32'h3, 32'ha: bus_access(1'b0, adr, 32'h0, 1'b0);
        32'h4: begin
          gpio_a_i <= dat[7:0];
          gpio_b_i <= dat[15:8];
          switch_i <= dat[18:16];
          @(posedge i_clk);
        end
        32'h5: repeat (dat) @(posedge i_clk);
        32'h6: wait_irq(mask[1:0], exp[1:0], dat);
        32'h7: bus_access(1'b1, adr, dat, 1'b1);
        32'h8: release_bus();
        32'h9: pulse_check(2'd1);
        default: begin
          $display("test %0d: unknown operation %h in the vector file", idx + 1, op);
          other_fail_cnt++;
          done = 1'b1;
        end
      endcase
      idx++;
    end

    // let the last checker update settle
    repeat (2) @(posedge i_clk);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt + other_fail_cnt);
    if (fail_cnt == 0 && other_fail_cnt == 0 && pass_cnt > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* deca_golden_vectors.txt */
// columns: op addr data expected mask, all hex, one test per line
// op 1 wr, 2 rd, 3 rd with err, 4 pins {sw,b,a}, 5 wait, 6 irq wait {ext,timer},
// 7 held wr, 8 release, 9 pins {b_oe,b,a_oe,a}, a rd above last, 0 end
1 00000000 000000a5 00000000 ffffffff
1 00000004 000000f0 00000000 ffffffff
1 00000100 0000003c 00000000 ffffffff
1 00000104 0000000f 00000000 ffffffff
9 00000000 00000000 0f3cf0a5 ffffffff
2 00000000 00000000 000000a5 ffffffff
2 00000004 00000000 000000f0 ffffffff
2 00000100 00000000 0000003c ffffffff
2 00000104 00000000 0000000f ffffffff
// gpio inputs after the sync chain
4 00000000 0000c35a 00000000 00000000
5 00000000 00000003 00000000 00000000
2 00000008 00000000 0000005a ffffffff
2 00000108 00000000 000000c3 ffffffff
// unmapped slaves, absent offsets, read-only input
3 00000400 00000000 00000000 ffffffff
3 00000f08 00000000 00000000 ffffffff
2 0000000c 00000000 00000000 ffffffff
2 0000020c 00000000 00000000 ffffffff
1 00000008 000000ff 00000000 ffffffff
2 00000008 00000000 0000005a ffffffff
// timer count, compare and irq
2 00000304 00000000 00000000 ffffffff
2 00000300 00000000 00000000 00000000
a 00000300 00000000 00000000 00000000
1 00000300 00000000 00000000 ffffffff
1 00000308 00000080 00000000 ffffffff
1 0000030c 00000000 00000000 ffffffff
2 00000308 00000000 00000080 ffffffff
6 00000000 00000004 00000000 00000001
6 00000000 00000200 00000001 00000001
1 0000030c ffffffff 00000000 ffffffff
1 00000308 ffffffff 00000000 ffffffff
6 00000000 00000008 00000000 00000001
// switch edge, enable, clear
4 00000000 0001c35a 00000000 00000000
5 00000000 00000006 00000000 00000000
2 00000204 00000000 00000001 00000007
6 00000000 00000004 00000000 00000002
1 00000208 00000001 00000000 ffffffff
6 00000000 00000010 00000002 00000002
1 00000204 00000001 00000000 ffffffff
6 00000000 00000010 00000000 00000002
2 00000204 00000000 00000000 00000007
// falling edge leaves pending alone
4 00000000 0000c35a 00000000 00000000
5 00000000 00000006 00000000 00000000
2 00000204 00000000 00000000 00000007
2 00000200 00000000 00000000 00000007
// held clear, new edge lands during the hold
4 00000000 0001c35a 00000000 00000000
5 00000000 00000006 00000000 00000000
2 00000204 00000000 00000001 00000007
4 00000000 0000c35a 00000000 00000000
5 00000000 00000006 00000000 00000000
7 00000204 00000001 00000000 ffffffff
4 00000000 0001c35a 00000000 00000000
5 00000000 00000008 00000000 00000000
8 00000000 00000000 00000000 00000000
2 00000204 00000000 00000001 00000007
0 00000000 00000000 00000000 00000000

/* tb.f */
+incdir+.
deca_pkg.sv
wb_addr_decode.sv
gpio_port.sv
switch_irq_ctrl.sv
machine_timer.sv
wb_read_mux.sv
deca_periph_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
